//--- source/vertex_job_pkg.sv
// shared widths, array and state enums, and bus structs for the vertex job controller
package vertex_job_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	localparam int vertex_width      = 32;
	localparam int vertices_per_line = 8;
	localparam int line_width        = vertex_width * vertices_per_line;
	localparam int line_bytes        = line_width / 8;
	localparam int count_width       = 16;
	localparam int addr_width        = 32;
	// per-chunk vertex count, 1 to 8
	localparam int vcount_width      = 4;

	////////////////////////////////////////////////////////////////////////////
	// enums
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		out_degree,
		graph_data,
		edges_idx
	} array_sel_e;

	typedef enum logic [2:0] {
		idle,
		size_chunk,
		send_out_degree,
		send_graph_data,
		send_edges_idx,
		wait_lines,
		shift_vertices
	} seq_state_e;

	////////////////////////////////////////////////////////////////////////////
	// structs
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [count_width-1:0] num_vertices;
		logic [addr_width-1:0]  out_degree_base;
		logic [addr_width-1:0]  edges_idx_base;
		logic [addr_width-1:0]  data_base;
	} job_desc_t;

	typedef struct packed {
		logic                    valid;
		logic [addr_width-1:0]   address;
		array_sel_e              array_sel;
		logic [vcount_width-1:0] vertex_count;
	} read_cmd_t;

	// one whole cacheline, tagged by array and count
	typedef struct packed {
		logic                    valid;
		array_sel_e              array_sel;
		logic [vcount_width-1:0] vertex_count;
		logic [line_width-1:0]   data;
	} read_line_t;

	typedef struct packed {
		logic                    valid;
		logic [count_width-1:0]  id;
		logic [vertex_width-1:0] out_degree;
		logic [vertex_width-1:0] edges_idx;
		logic [vertex_width-1:0] data;
	} vertex_job_t;

endpackage

//--- source/sync_fifo.sv
// synchronous FIFO with a live head view and a registered pop output, used for both queues
`timescale 1ns/10ps

module sync_fifo #(
	parameter int width      = 8,
	parameter int depth      = 16,
	parameter int room_level = 1
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [width-1:0] data_in,
	input  logic             pop,
	output logic [width-1:0] data_out,
	output logic [width-1:0] head,
	output logic             empty,
	output logic             full,
	output logic             room
);

	localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_width = $clog2(depth + 1);

	logic [width-1:0]     mem [depth];
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic [cnt_width-1:0] count;
	logic                 do_push;
	logic                 do_pop;

	assign empty   = (count == '0);
	assign full    = (count == cnt_width'(depth));
	assign room    = ((cnt_width'(depth) - count) >= cnt_width'(room_level));
	// pops on an empty queue are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign head    = empty ? '0 : mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			data_out <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
			// zero when idle so a struct valid bit reads as a strobe
			data_out <= do_pop ? mem[rd_ptr] : '0;
		end
	end

	push_when_full: assert property (@(posedge clock) disable iff (!rstn) push |-> !full);

	// single entry comes back unchanged
	round_trip: assert property (@(posedge clock) disable iff (!rstn)
		(empty && push) ##1 pop |=> (data_out == $past(data_in, 2)));

endmodule

//--- source/vertex_read_sequencer.sv
// job FSM that sizes each chunk, queues its three read commands and paces the unpacking
`timescale 1ns/10ps

module vertex_read_sequencer (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      job_start,
	input  vertex_job_pkg::job_desc_t job,
	input  logic                      cmd_empty,
	input  logic                      vertex_room,
	input  logic                      lines_ready,
	output logic                      busy,
	output vertex_job_pkg::read_cmd_t cmd_push,
	output logic                      shift,
	output logic                      chunk_clear,
	output logic [3:0]                chunk_count
);

	import vertex_job_pkg::*;

	seq_state_e              state;
	seq_state_e              next_state;
	job_desc_t               desc;
	logic [count_width-1:0]  remaining;
	logic [addr_width-1:0]   offset;
	logic [vcount_width-1:0] shift_count;
	logic [vcount_width-1:0] chunk_size;
	logic                    job_accept;
	logic                    chunk_go;
	logic                    last_shift;

	assign job_accept = job_start && (state == idle) && (remaining == '0) &&
		(job.num_vertices != '0);
	// start a chunk only with an empty command queue and room for a line of vertices
	assign chunk_go   = (job_accept || (remaining != '0)) && cmd_empty && vertex_room;
	assign chunk_size = (remaining > count_width'(vertices_per_line)) ?
		vcount_width'(vertices_per_line) : remaining[vcount_width-1:0];
	assign last_shift = (shift_count == chunk_count - 1'b1);

	assign busy        = !((state == idle) && (remaining == '0));
	assign shift       = (state == shift_vertices);
	assign chunk_clear = shift && last_shift;

	////////////////////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			idle:            if (chunk_go) next_state = size_chunk;
			size_chunk:      next_state = send_out_degree;
			send_out_degree: next_state = send_graph_data;
			send_graph_data: next_state = send_edges_idx;
			send_edges_idx:  next_state = wait_lines;
			wait_lines:      if (lines_ready) next_state = shift_vertices;
			shift_vertices:  if (last_shift) next_state = idle;
			default:         next_state = idle;
		endcase
	end

	// fixed order: out-degree, data, edge index
	always_comb begin
		cmd_push = '0;
		case (state)
			send_out_degree: begin
				cmd_push.valid        = 1'b1;
				cmd_push.address      = desc.out_degree_base + offset;
				cmd_push.array_sel    = out_degree;
				cmd_push.vertex_count = chunk_count;
			end
			send_graph_data: begin
				cmd_push.valid        = 1'b1;
				cmd_push.address      = desc.data_base + offset;
				cmd_push.array_sel    = graph_data;
				cmd_push.vertex_count = chunk_count;
			end
			send_edges_idx: begin
				cmd_push.valid        = 1'b1;
				cmd_push.address      = desc.edges_idx_base + offset;
				cmd_push.array_sel    = edges_idx;
				cmd_push.vertex_count = chunk_count;
			end
			default: cmd_push = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (job_accept)
			desc <= job;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= idle;
			remaining   <= '0;
			offset      <= '0;
			chunk_count <= '0;
			shift_count <= '0;
		end else begin
			state <= next_state;
			if (job_accept) begin
				remaining <= job.num_vertices;
				offset    <= '0;
			end
			if (state == size_chunk) begin
				chunk_count <= chunk_size;
				remaining   <= remaining - count_width'(chunk_size);
			end
			// next cacheline once the last command of the chunk is out
			if (state == send_edges_idx)
				offset <= offset + addr_width'(line_bytes);
			shift_count <= shift ? shift_count + 1'b1 : '0;
		end
	end

	// a job offered while busy would be dropped without notice
	job_when_busy: assert property (@(posedge clock) disable iff (!rstn)
		job_start |-> !busy);

	// unpacker holds all three lines for the whole shift
	shift_with_lines: assert property (@(posedge clock) disable iff (!rstn)
		shift |-> lines_ready);

endmodule

//--- source/vertex_line_unpacker.sv
// holds the three returned lines of a chunk and emits one vertex job per shift cycle
`timescale 1ns/10ps

module vertex_line_unpacker (
	input  logic                        clock,
	input  logic                        rstn,
	input  vertex_job_pkg::read_line_t  read_line,
	input  logic                        shift,
	input  logic                        chunk_clear,
	input  logic                        job_start,
	output logic                        lines_ready,
	output vertex_job_pkg::vertex_job_t vertex_push
);

	import vertex_job_pkg::*;

	logic [line_width-1:0]  degree_line;
	logic [line_width-1:0]  data_line;
	logic [line_width-1:0]  edges_line;
	// one flag per array_sel value
	logic [2:0]             arrived;
	logic [count_width-1:0] id_count;

	assign lines_ready = &arrived;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			arrived <= '0;
		else if (chunk_clear)
			arrived <= '0;
		else if (read_line.valid)
			arrived[read_line.array_sel] <= 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// line registers, vertex 0 in the low bits
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (shift) begin
			degree_line <= degree_line >> vertex_width;
			data_line   <= data_line >> vertex_width;
			edges_line  <= edges_line >> vertex_width;
		end
		if (read_line.valid) begin
			case (read_line.array_sel)
				out_degree: degree_line <= read_line.data;
				graph_data: data_line   <= read_line.data;
				edges_idx:  edges_line  <= read_line.data;
				default:    ;
			endcase
		end
	end

	// ids count from 0 within each job
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			id_count <= '0;
		else if (job_start)
			id_count <= '0;
		else if (shift)
			id_count <= id_count + 1'b1;
	end

	always_comb begin
		vertex_push = '0;
		if (shift) begin
			vertex_push.valid      = 1'b1;
			vertex_push.id         = id_count;
			vertex_push.out_degree = degree_line[vertex_width-1:0];
			vertex_push.edges_idx  = edges_line[vertex_width-1:0];
			vertex_push.data       = data_line[vertex_width-1:0];
		end
	end

	line_once: assert property (@(posedge clock) disable iff (!rstn)
		read_line.valid |-> !arrived[read_line.array_sel]);

endmodule

//--- source/vertex_job_control.sv
// vertex job controller top, ties the sequencer and unpacker to the command and vertex FIFOs
`timescale 1ns/10ps

module vertex_job_control #(
	parameter int cmd_depth    = 16,
	parameter int vertex_depth = 32
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        job_start,
	input  vertex_job_pkg::job_desc_t   job,
	input  logic                        cmd_grant,
	input  vertex_job_pkg::read_line_t  read_line,
	input  logic                        vertex_request,
	output logic                        busy,
	output logic                        cmd_request,
	output vertex_job_pkg::read_cmd_t   cmd,
	output vertex_job_pkg::vertex_job_t vertex
);

	import vertex_job_pkg::*;

	read_cmd_t               cmd_push;
	vertex_job_t             vertex_push;
	logic                    cmd_empty;
	logic                    vertex_room;
	logic                    lines_ready;
	logic                    shift;
	logic                    chunk_clear;
	logic [vcount_width-1:0] chunk_count;

	// head valid bit tracks this flag
	assign cmd_request = ~cmd_empty;

	////////////////////////////////////////////////////////////////////////////
	// job sequencing and line unpacking
	////////////////////////////////////////////////////////////////////////////

	vertex_read_sequencer vertex_read_sequencer_i (
		.clock       (clock),
		.rstn        (rstn),
		.job_start   (job_start),
		.job         (job),
		.cmd_empty   (cmd_empty),
		.vertex_room (vertex_room),
		.lines_ready (lines_ready),
		.busy        (busy),
		.cmd_push    (cmd_push),
		.shift       (shift),
		.chunk_clear (chunk_clear),
		.chunk_count (chunk_count)
	);

	vertex_line_unpacker vertex_line_unpacker_i (
		.clock       (clock),
		.rstn        (rstn),
		.read_line   (read_line),
		.shift       (shift),
		.chunk_clear (chunk_clear),
		.job_start   (job_start),
		.lines_ready (lines_ready),
		.vertex_push (vertex_push)
	);

	////////////////////////////////////////////////////////////////////////////
	// queues
	////////////////////////////////////////////////////////////////////////////

	// memory side reads the head directly and grants to advance
	sync_fifo #(
		.width      ($bits(read_cmd_t)),
		.depth      (cmd_depth),
		.room_level (3)
	) cmd_fifo_i (
		.clock    (clock),
		.rstn     (rstn),
		.push     (cmd_push.valid),
		.data_in  (cmd_push),
		.pop      (cmd_grant),
		.data_out (),
		.head     (cmd),
		.empty    (cmd_empty),
		.full     (),
		.room     ()
	);

	// room for one full line of vertices
	sync_fifo #(
		.width      ($bits(vertex_job_t)),
		.depth      (vertex_depth),
		.room_level (vertices_per_line)
	) vertex_fifo_i (
		.clock    (clock),
		.rstn     (rstn),
		.push     (vertex_push.valid),
		.data_in  (vertex_push),
		.pop      (vertex_request),
		.data_out (vertex),
		.head     (),
		.empty    (),
		.full     (),
		.room     (vertex_room)
	);

	// returned lines carry the count the sequencer asked for
	line_count_match: assert property (@(posedge clock) disable iff (!rstn)
		read_line.valid |-> (read_line.vertex_count == chunk_count));

endmodule

//--- tests/vertex_job_checker.sv
// watches the vertex job controller ports, predicts commands and vertices, and counts errors
`timescale 1ns/10ps

module vertex_job_checker (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        job_start,
	input  vertex_job_pkg::job_desc_t   job,
	input  logic                        busy,
	input  logic                        cmd_request,
	input  logic                        cmd_grant,
	input  vertex_job_pkg::read_cmd_t   cmd,
	input  logic                        vertex_request,
	input  vertex_job_pkg::vertex_job_t vertex,
	input  logic [31:0]                 word_key,
	output int                          cmd_errors,
	output int                          vertex_errors,
	output int                          other_errors,
	output int                          outstanding
);

	import vertex_job_pkg::*;

	read_cmd_t   exp_cmd [$];
	vertex_job_t exp_vtx [$];
	int          n_cmd = 0;
	int          n_vtx = 0;
	int          n_other = 0;
	int          n_left = 0;
	int          job_index = -1;
	logic        request_seen = 1'b0;

	assign cmd_errors    = n_cmd;
	assign vertex_errors = n_vtx;
	assign other_errors  = n_other;
	assign outstanding   = n_left;

	function automatic logic [31:0] mem_word(input logic [31:0] addr, input logic [31:0] key);
		logic [31:0] x;
		x = (addr ^ key) * 32'h9e37_79b1;
		x = x ^ (x >> 15);
		x = x * 32'h85eb_ca6b;
		return x ^ (x >> 13);
	endfunction

	task automatic report_mismatch(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
	endtask

	// three commands per chunk, then one vertex per id
	task automatic predict_job(input job_desc_t d);
		read_cmd_t   c;
		vertex_job_t v;
		int          n;
		n = int'(d.num_vertices);
		// k steps by a line, so k * 4 is the chunk offset of 32 bytes
		for (int k = 0; k < n; k += vertices_per_line) begin
			c = '0;
			c.valid        = 1'b1;
			c.vertex_count = vcount_width'((n - k > vertices_per_line) ? vertices_per_line : n - k);
			c.address      = d.out_degree_base + addr_width'(k * 4);
			c.array_sel    = out_degree;
			exp_cmd.push_back(c);
			c.address      = d.data_base + addr_width'(k * 4);
			c.array_sel    = graph_data;
			exp_cmd.push_back(c);
			c.address      = d.edges_idx_base + addr_width'(k * 4);
			c.array_sel    = edges_idx;
			exp_cmd.push_back(c);
		end
		for (int k = 0; k < n; k++) begin
			v.valid      = 1'b1;
			v.id         = count_width'(k);
			v.out_degree = mem_word(d.out_degree_base + addr_width'(k * 4), word_key);
			v.edges_idx  = mem_word(d.edges_idx_base + addr_width'(k * 4), word_key);
			v.data       = mem_word(d.data_base + addr_width'(k * 4), word_key);
			exp_vtx.push_back(v);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// sampled mid cycle, away from the clock edge
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin : compare
		if (!rstn) begin
			if (cmd_request || busy || vertex.valid) begin
				n_other++;
				$display("outputs not low during reset at %0t", $time);
			end
		end else begin
			// every command of a job goes out before the job can finish
			if (!busy && exp_cmd.size() != 0) begin
				n_other++;
				$display("busy low with %0d commands still due at %0t", exp_cmd.size(), $time);
			end
			if (job_start && !busy && job.num_vertices != '0) begin
				job_index++;
				predict_job(job);
			end
			if (cmd.valid != cmd_request) begin
				n_other++;
				$display("cmd valid bit disagrees with cmd_request at %0t", $time);
			end
			if (cmd_grant && cmd_request) begin
				if (exp_cmd.size() == 0) begin
					n_cmd++;
					$display("command %h granted with none predicted at %0t", cmd, $time);
				end else begin
					if (cmd !== exp_cmd[0]) begin
						n_cmd++;
						report_mismatch($sformatf("job%0d_commands", job_index), exp_cmd[0], cmd);
					end
					void'(exp_cmd.pop_front());
				end
			end
			if (vertex.valid) begin
				if (!request_seen) begin
					n_vtx++;
					$display("valid vertex without a request the cycle before at %0t", $time);
				end
				if (exp_vtx.size() == 0) begin
					n_vtx++;
					$display("extra vertex %h delivered at %0t", vertex, $time);
				end else begin
					if (vertex !== exp_vtx[0]) begin
						n_vtx++;
						report_mismatch($sformatf("job%0d_vertex_contents", job_index),
							exp_vtx[0], vertex);
					end
					void'(exp_vtx.pop_front());
				end
			end
		end
		request_seen = vertex_request;
		n_left = exp_cmd.size() + exp_vtx.size();
	end

endmodule

//--- tests/vertex_job_control_tb.sv
// testbench top for the vertex job controller, runs seeded random jobs against a memory model
`timescale 1ns/10ps

module vertex_job_control_tb;

	import vertex_job_pkg::*;

	localparam int job_total = 6;

	logic        clock = 1'b0;
	logic        rstn;
	logic        job_start;
	job_desc_t   job;
	logic        cmd_grant;
	read_line_t  read_line;
	logic        vertex_request;
	logic        busy;
	logic        cmd_request;
	read_cmd_t   cmd;
	vertex_job_t vertex;

	logic [31:0] word_key;
	int          cycle = 0;
	int          cycle_limit = 0;
	int          sent = 0;
	int          received = 0;
	int          run_errors = 0;
	int          cmd_errors;
	int          vertex_errors;
	int          other_errors;
	int          outstanding;
	int          sizes [job_total];
	// granted commands waiting for their line to come back
	read_cmd_t   pend_cmd [$];
	int          pend_due [$];

	always #4 clock = ~clock;

	vertex_job_control #(
		.cmd_depth    (16),
		.vertex_depth (32)
	) vertex_job_control_i (
		.clock          (clock),
		.rstn           (rstn),
		.job_start      (job_start),
		.job            (job),
		.cmd_grant      (cmd_grant),
		.read_line      (read_line),
		.vertex_request (vertex_request),
		.busy           (busy),
		.cmd_request    (cmd_request),
		.cmd            (cmd),
		.vertex         (vertex)
	);

	vertex_job_checker vertex_job_checker_i (
		.clock          (clock),
		.rstn           (rstn),
		.job_start      (job_start),
		.job            (job),
		.busy           (busy),
		.cmd_request    (cmd_request),
		.cmd_grant      (cmd_grant),
		.cmd            (cmd),
		.vertex_request (vertex_request),
		.vertex         (vertex),
		.word_key       (word_key),
		.cmd_errors     (cmd_errors),
		.vertex_errors  (vertex_errors),
		.other_errors   (other_errors),
		.outstanding    (outstanding)
	);

	// memory contents, a keyed hash of the byte address
	function automatic logic [31:0] mem_word(input logic [31:0] addr, input logic [31:0] key);
		logic [31:0] x;
		x = (addr ^ key) * 32'h9e37_79b1;
		x = x ^ (x >> 15);
		x = x * 32'h85eb_ca6b;
		return x ^ (x >> 13);
	endfunction

	function automatic read_line_t fill_line(input read_cmd_t c);
		read_line_t l;
		l = '0;
		l.valid        = 1'b1;
		l.array_sel    = c.array_sel;
		l.vertex_count = c.vertex_count;
		for (int v = 0; v < vertices_per_line; v++)
			if (v < int'(c.vertex_count))
				l.data[v*vertex_width +: vertex_width] = mem_word(c.address + 32'(4 * v), word_key);
		return l;
	endfunction

	function automatic logic [31:0] random_base();
		return $urandom() & 32'hffff_fff0;
	endfunction

	task automatic wait_for_idle();
		do
			@(posedge clock);
		while (busy || received != sent);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// memory side and consumer
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin : memory_model
		read_line_t line_out;
		int         pick;
		line_out = '0;
		pick = -1;
		if (!rstn) begin
			cmd_grant <= 1'b0;
			read_line <= '0;
		end else begin
			// no grant right after a grant, the head may have just emptied
			cmd_grant <= cmd_request && !cmd_grant && ($urandom_range(99) < 55);
			if (cmd_grant) begin
				pend_cmd.push_back(cmd);
				pend_due.push_back(cycle + int'($urandom_range(10, 1)));
			end
			// one line per cycle, the first one that is due
			foreach (pend_due[i])
				if (pick < 0 && pend_due[i] <= cycle)
					pick = i;
			if (pick >= 0) begin
				line_out = fill_line(pend_cmd[pick]);
				pend_cmd.delete(pick);
				pend_due.delete(pick);
			end
			read_line <= line_out;
		end
	end

	always @(posedge clock) begin : consumer
		if (!rstn)
			vertex_request <= 1'b0;
		else
			vertex_request <= ($urandom_range(99) < 40);
		if (vertex.valid)
			received <= received + 1;
	end

	always @(posedge clock) begin : watchdog
		cycle <= cycle + 1;
		if (cycle_limit > 0 && cycle >= cycle_limit) begin
			$display("timeout, run still going after %0d cycles", cycle_limit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// job sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		int        seed_value;
		int        total;
		job_desc_t desc;
		seed_value     = 755;
		total          = 0;
		void'($urandom(seed_value));
		rstn           = 1'b0;
		job_start      = 1'b0;
		job            = '0;
		cmd_grant      = 1'b0;
		read_line      = '0;
		vertex_request = 1'b0;
		word_key       = $urandom();
		for (int j = 0; j < job_total; j++) begin
			sizes[j] = int'($urandom_range(40, 1));
			total    = total + sizes[j];
		end
		cycle_limit = total * 40 + 2000;
		repeat (16) @(posedge clock);
		rstn <= 1'b1;
		for (int j = 0; j < job_total; j++) begin
			wait_for_idle();
			desc.num_vertices    = count_width'(sizes[j]);
			desc.out_degree_base = random_base();
			desc.edges_idx_base  = random_base();
			desc.data_base       = random_base();
			job       <= desc;
			job_start <= 1'b1;
			sent = sent + sizes[j];
			@(posedge clock);
			job_start <= 1'b0;
		end
		wait_for_idle();
		repeat (20) @(posedge clock);
		if (outstanding != 0) begin
			run_errors++;
			$display("%0d predicted commands or vertices never showed up", outstanding);
		end
		$display("errors: command %0d, vertex %0d, other %0d", cmd_errors, vertex_errors,
			other_errors + run_errors);
		if (cmd_errors + vertex_errors + other_errors + run_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- tb.f
source/vertex_job_pkg.sv
source/sync_fifo.sv
source/vertex_read_sequencer.sv
source/vertex_line_unpacker.sv
source/vertex_job_control.sv
tests/vertex_job_checker.sv
tests/vertex_job_control_tb.sv
